/* logic/i2c_bridge_params.svh */
`ifndef I2C_BRIDGE_PARAMS_SVH
`define I2C_BRIDGE_PARAMS_SVH

// Target address width.
`define I2C_ADDR_WIDTH 7

// Data byte width.
`define I2C_DATA_WIDTH 8

// Bit counter, wide enough for the longest field.
`define I2C_CNT_WIDTH 3

// Number of bus engines.
`define I2C_CHANNELS 4

// Channel field width.
`define I2C_CHAN_WIDTH 2

`endif

/* logic/i2c_bridge_pkg.sv */
`include "i2c_bridge_params.svh"

package i2c_bridge_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } i2c_op_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_START    = 3'd1,
        ST_ADDR     = 3'd2,
        ST_RW       = 3'd3,
        ST_ACK_ADDR = 3'd4,
        ST_DATA     = 3'd5,
        ST_ACK_DATA = 3'd6,
        ST_STOP     = 3'd7
    } i2c_state_e;

    typedef struct packed {
        logic [`I2C_CHAN_WIDTH-1:0] chan;
        logic [`I2C_DATA_WIDTH-1:0] data; // Ignored for reads.
        i2c_op_e                    op;
        logic [`I2C_ADDR_WIDTH-1:0] addr;
    } i2c_cmd_t;

    typedef struct packed {
        logic [`I2C_CHAN_WIDTH-1:0] chan;
        logic [`I2C_ADDR_WIDTH-1:0] addr;
        logic [`I2C_DATA_WIDTH-1:0] data;
    } i2c_rsp_t;

endpackage

/* logic/i2c_cmd_dispatch.sv */
`timescale 1ns/1ns

`include "i2c_bridge_params.svh"

module i2c_cmd_dispatch (
    input  i2c_bridge_pkg::i2c_cmd_t   cmd_i,
    input  logic                       cmd_valid_i,
    output logic                       cmd_ready_o,

    output i2c_bridge_pkg::i2c_cmd_t   eng_cmd_o,
    output logic [`I2C_CHANNELS-1:0]   eng_valid_o,
    input  logic [`I2C_CHANNELS-1:0]   eng_ready_i
);

    logic [`I2C_CHANNELS-1:0] chan_hit;

    // One-hot decode of the channel field.
    always_comb begin
        chan_hit = '0;
        for (int c = 0; c < `I2C_CHANNELS; c++) begin
            if (cmd_i.chan == `I2C_CHAN_WIDTH'(c)) begin
                chan_hit[c] = 1'b1;
            end
        end
    end

    // Only the named engine sees valid.
    always_comb begin
        eng_valid_o = '0;
        if (cmd_valid_i) begin
            eng_valid_o = chan_hit;
        end
    end

    // A busy target channel holds the whole stream.
    always_comb begin
        cmd_ready_o = |(chan_hit & eng_ready_i);
    end

    assign eng_cmd_o = cmd_i; // Shared by all engines.

endmodule

/* logic/i2c_bus_engine.sv */
`timescale 1ns/1ns

`include "i2c_bridge_params.svh"

module i2c_bus_engine (
    input  logic                          clk_i,
    input  logic                          arstn_i,

    input  i2c_bridge_pkg::i2c_cmd_t      cmd_i,
    input  logic                          cmd_valid_i,
    output logic                          cmd_ready_o,

    output logic [`I2C_DATA_WIDTH-1:0]    rsp_data_o,
    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    output logic [`I2C_ADDR_WIDTH-1:0]    addr_o,

    output logic                          scl_o,
    output logic                          sda_en_o,
    output logic                          sda_o,
    input  logic                          sda_i
);

    import i2c_bridge_pkg::*;

    i2c_state_e                 state;
    logic [`I2C_CNT_WIDTH-1:0]  cnt;
    logic                       scl_en;

    logic [`I2C_ADDR_WIDTH-1:0] addr_q;
    logic [`I2C_DATA_WIDTH-1:0] data_q;
    i2c_op_e                    op_q;
    logic [`I2C_DATA_WIDTH-1:0] rx_q;
    logic                       rx_shift;

    // Frame sequencer.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            sda_o    <= 1'b1;
            sda_en_o <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid_i) begin
                        state <= ST_START;
                        cnt   <= '0;
                    end
                end
                ST_START: begin
                    sda_o <= 1'b0; // Start condition, SCL still high.
                    state <= ST_ADDR;
                end
                ST_ADDR: begin
                    sda_o <= addr_q[cnt];
                    if (cnt == `I2C_CNT_WIDTH'(`I2C_ADDR_WIDTH - 1)) begin
                        cnt   <= '0;
                        state <= ST_RW;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_RW: begin
                    sda_o <= (op_q == OP_READ);
                    state <= ST_ACK_ADDR;
                end
                ST_ACK_ADDR: begin
                    sda_en_o <= (op_q == OP_WRITE); // Release the line for reads.
                    state    <= ST_DATA;
                end
                ST_DATA: begin
                    if (op_q == OP_WRITE) begin
                        sda_o <= data_q[cnt];
                    end
                    if (cnt == `I2C_CNT_WIDTH'(`I2C_DATA_WIDTH - 1)) begin
                        cnt   <= '0;
                        state <= ST_ACK_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_ACK_DATA: begin
                    sda_en_o <= 1'b1;
                    sda_o    <= 1'b0; // Low so the stop edge can rise.
                    state    <= ST_STOP;
                end
                ST_STOP: begin
                    if ((op_q == OP_WRITE) || rsp_ready_i) begin
                        sda_o <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read bits land one clock after each data SCL rise.
    assign rx_shift = (op_q == OP_READ) &&
                      (((state == ST_DATA) && (cnt != '0)) || (state == ST_ACK_DATA));

    always_ff @(posedge clk_i) begin
        if ((state == ST_IDLE) && cmd_valid_i) begin
            addr_q <= cmd_i.addr;
            data_q <= cmd_i.data;
            op_q   <= cmd_i.op;
        end
        if (rx_shift) begin
            rx_q <= {sda_i, rx_q[`I2C_DATA_WIDTH-1:1]}; // LSB arrives first.
        end
    end

    // SCL gate moves on the falling clock to avoid glitches.
    always_ff @(negedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            scl_en <= 1'b0;
        end else begin
            scl_en <= (state != ST_IDLE) && (state != ST_START) && (state != ST_STOP);
        end
    end

    assign scl_o       = scl_en ? ~clk_i : 1'b1;
    assign cmd_ready_o = (state == ST_IDLE);
    assign rsp_valid_o = (state == ST_STOP) && (op_q == OP_READ);
    assign rsp_data_o  = rx_q;
    assign addr_o      = addr_q;

endmodule

/* logic/i2c_rsp_collect.sv */
`timescale 1ns/1ns

`include "i2c_bridge_params.svh"

module i2c_rsp_collect (
    input  logic                                            clk_i,
    input  logic                                            arstn_i,

    input  logic [`I2C_CHANNELS-1:0][`I2C_DATA_WIDTH-1:0]   eng_data_i,
    input  logic [`I2C_CHANNELS-1:0]                        eng_valid_i,
    output logic [`I2C_CHANNELS-1:0]                        eng_ready_o,
    input  logic [`I2C_CHANNELS-1:0][`I2C_ADDR_WIDTH-1:0]   eng_addr_i,

    output i2c_bridge_pkg::i2c_rsp_t                        rsp_o,
    output logic                                            rsp_valid_o,
    input  logic                                            rsp_ready_i
);

    logic [`I2C_CHANNELS-1:0]                      full;
    logic [`I2C_CHANNELS-1:0][`I2C_DATA_WIDTH-1:0] slot_data;
    logic [`I2C_CHANNELS-1:0][`I2C_ADDR_WIDTH-1:0] slot_addr;

    logic [`I2C_CHAN_WIDTH-1:0] rr_ptr;
    logic [`I2C_CHAN_WIDTH-1:0] sel;
    logic                       sel_valid;
    logic [`I2C_CHAN_WIDTH-1:0] pick_idx;
    logic                       pick_found;

    // First full slot at or after the pointer.
    always_comb begin
        logic [`I2C_CHAN_WIDTH-1:0] idx;
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        for (int i = 0; i < `I2C_CHANNELS; i++) begin
            idx = rr_ptr + `I2C_CHAN_WIDTH'(i);
            if (!pick_found && full[idx]) begin
                pick_found = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            full      <= '0;
            rr_ptr    <= '0;
            sel       <= '0;
            sel_valid <= 1'b0;
        end else begin
            for (int c = 0; c < `I2C_CHANNELS; c++) begin
                if (eng_valid_i[c] && !full[c]) begin
                    full[c] <= 1'b1;
                end
            end
            if (sel_valid) begin
                if (rsp_ready_i) begin
                    full[sel] <= 1'b0;
                    sel_valid <= 1'b0;
                    rr_ptr    <= sel + 1'b1; // Next search starts past the winner.
                end
            end else if (pick_found) begin
                sel       <= pick_idx; // Locked until taken.
                sel_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < `I2C_CHANNELS; c++) begin
            if (eng_valid_i[c] && !full[c]) begin
                slot_data[c] <= eng_data_i[c];
                slot_addr[c] <= eng_addr_i[c];
            end
        end
    end

    assign eng_ready_o = ~full;
    assign rsp_valid_o = sel_valid;
    assign rsp_o.chan  = sel;
    assign rsp_o.addr  = slot_addr[sel];
    assign rsp_o.data  = slot_data[sel];

endmodule

/* logic/i2c_bridge_top.sv */
`timescale 1ns/1ns

`include "i2c_bridge_params.svh"

module i2c_bridge_top (
    input  logic                        clk_i,
    input  logic                        arstn_i,

    input  i2c_bridge_pkg::i2c_cmd_t    cmd_i,
    input  logic                        cmd_valid_i,
    output logic                        cmd_ready_o,

    output i2c_bridge_pkg::i2c_rsp_t    rsp_o,
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,

    output logic [`I2C_CHANNELS-1:0]    scl_o,
    output logic [`I2C_CHANNELS-1:0]    sda_en_o,
    output logic [`I2C_CHANNELS-1:0]    sda_o,
    input  logic [`I2C_CHANNELS-1:0]    sda_i
);

    import i2c_bridge_pkg::*;

    i2c_cmd_t                                      eng_cmd;
    logic [`I2C_CHANNELS-1:0]                      eng_valid;
    logic [`I2C_CHANNELS-1:0]                      eng_ready;
    logic [`I2C_CHANNELS-1:0][`I2C_DATA_WIDTH-1:0] eng_rsp_data;
    logic [`I2C_CHANNELS-1:0][`I2C_ADDR_WIDTH-1:0] eng_addr;
    logic [`I2C_CHANNELS-1:0]                      eng_rsp_valid;
    logic [`I2C_CHANNELS-1:0]                      eng_rsp_ready;

    i2c_cmd_dispatch u_dispatch (
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .eng_cmd_o   (eng_cmd),
        .eng_valid_o (eng_valid),
        .eng_ready_i (eng_ready)
    );

    for (genvar ch = 0; ch < `I2C_CHANNELS; ch++) begin : g_eng
        i2c_bus_engine u_engine (
            .clk_i       (clk_i),
            .arstn_i     (arstn_i),
            .cmd_i       (eng_cmd),
            .cmd_valid_i (eng_valid[ch]),
            .cmd_ready_o (eng_ready[ch]),
            .rsp_data_o  (eng_rsp_data[ch]),
            .rsp_valid_o (eng_rsp_valid[ch]),
            .rsp_ready_i (eng_rsp_ready[ch]),
            .addr_o      (eng_addr[ch]),
            .scl_o       (scl_o[ch]),
            .sda_en_o    (sda_en_o[ch]),
            .sda_o       (sda_o[ch]),
            .sda_i       (sda_i[ch])
        );
    end

    i2c_rsp_collect u_collect (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .eng_data_i  (eng_rsp_data),
        .eng_valid_i (eng_rsp_valid),
        .eng_ready_o (eng_rsp_ready),
        .eng_addr_i  (eng_addr),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

/* bench/i2c_target_model.sv */
`timescale 1ns/1ns

module i2c_target_model (
    input  logic        scl_i,
    input  logic        sda_m_i,
    input  logic        sda_en_i,
    output logic        sda_o,
    input  logic [7:0]  rd_byte_i,
    output logic [16:0] frame_log_o,
    output int          frame_cnt_o,
    output int          edge_cnt_o
);

    logic        scl_q;
    logic        sda_q;
    logic        in_frame;
    logic [4:0]  bit_cnt;
    logic [16:0] frame_bits;
    logic [2:0]  rd_idx;
    logic        bus;

    initial begin
        sda_o       = 1'b1;
        frame_log_o = '0;
        frame_cnt_o = 0;
        edge_cnt_o  = 0;
        in_frame    = 1'b0;
        bit_cnt     = '0;
        frame_bits  = '0;
        scl_q       = 1'b1;
        sda_q       = 1'b1;
    end

    assign bus = sda_en_i ? sda_m_i : sda_o; // Wired bus line.

    always @(scl_i or sda_m_i) begin
        if ((scl_i === 1'b1) && (scl_q !== 1'b1)) begin
            edge_cnt_o = edge_cnt_o + 1;
            if (in_frame) begin
                if (bit_cnt < 5'd17) begin
                    frame_bits[bit_cnt] = bus; // Edge k lands in bit k-1.
                end
                if (bit_cnt < 5'd31) begin
                    bit_cnt = bit_cnt + 5'd1;
                end
            end
        end else if ((scl_i === 1'b0) && (scl_q === 1'b1)) begin
            // Data goes out while SCL is low.
            if (in_frame && frame_bits[7] && (bit_cnt >= 5'd9) && (bit_cnt <= 5'd16)) begin
                rd_idx = 3'(bit_cnt - 5'd9);
                sda_o <= rd_byte_i[rd_idx];
            end else begin
                sda_o <= 1'b1;
            end
        end
        if ((scl_i === 1'b1) && (scl_q === 1'b1)) begin
            if ((sda_m_i === 1'b0) && (sda_q === 1'b1) && !in_frame && sda_en_i) begin
                in_frame   = 1'b1; // Start condition.
                bit_cnt    = '0;
                frame_bits = '0;
            end else if ((sda_m_i === 1'b1) && (sda_q === 1'b0) && in_frame) begin
                in_frame    = 1'b0; // Stop condition.
                frame_log_o = frame_bits;
                frame_cnt_o = frame_cnt_o + 1;
            end
        end
        scl_q = scl_i;
        sda_q = sda_m_i;
    end

endmodule

/* bench/i2c_bridge_tb.sv */
`timescale 1ns/1ns

`include "i2c_bridge_params.svh"

module i2c_bridge_tb;

    import i2c_bridge_pkg::*;

    typedef struct packed {
        logic [1:0] chan;
        i2c_op_e    op;
        logic [6:0] addr;
        logic [7:0] wdata;
        logic [7:0] rdata;
        logic       last; // Closes a group of commands.
        logic       hold; // Response stream stalled for the group.
    } row_t;

    localparam int NUM_ROWS = 13;
    localparam int TIMEOUT  = 200;

    logic       clk;
    logic       arstn;
    i2c_cmd_t   cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    i2c_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    logic [3:0] scl;
    logic [3:0] sda_en;
    logic [3:0] sda;
    logic [3:0] sda_in;

    logic [7:0]  rd_byte [4];
    logic [16:0] frame_log [4];
    int          frame_cnt [4];
    int          edge_cnt [4];
    int          exp_frames [4];
    int          edge_snap [4];

    row_t       table_rows [NUM_ROWS];
    int         grp [$];
    i2c_rsp_t   rsp_q [$];
    int         value_errs;
    int         other_errs;
    int         timeouts;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    i2c_bridge_top dut_i (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .scl_o       (scl),
        .sda_en_o    (sda_en),
        .sda_o       (sda),
        .sda_i       (sda_in)
    );

    for (genvar ch = 0; ch < `I2C_CHANNELS; ch++) begin : g_tgt
        i2c_target_model u_target (
            .scl_i       (scl[ch]),
            .sda_m_i     (sda[ch]),
            .sda_en_i    (sda_en[ch]),
            .sda_o       (sda_in[ch]),
            .rd_byte_i   (rd_byte[ch]),
            .frame_log_o (frame_log[ch]),
            .frame_cnt_o (frame_cnt[ch]),
            .edge_cnt_o  (edge_cnt[ch])
        );
    end

    // Handshake seen here moves on the next rising edge.
    always @(negedge clk) begin
        if (arstn && rsp_valid && rsp_ready) begin
            rsp_q.push_back(rsp);
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            other_errs++;
            $display("Error: %s", msg);
        end
    endtask

    task automatic load_table();
        table_rows[0]  = '{2'd0, OP_WRITE, 7'h2A, 8'hC5, 8'h00, 1'b1, 1'b0};
        table_rows[1]  = '{2'd1, OP_READ,  7'h51, 8'h00, 8'h3C, 1'b1, 1'b0};
        table_rows[2]  = '{2'd2, OP_WRITE, 7'h13, 8'h80, 8'h00, 1'b1, 1'b0};
        table_rows[3]  = '{2'd3, OP_READ,  7'h7F, 8'h00, 8'hA6, 1'b1, 1'b0};
        table_rows[4]  = '{2'd0, OP_READ,  7'h11, 8'h00, 8'h5A, 1'b0, 1'b0};
        table_rows[5]  = '{2'd1, OP_READ,  7'h22, 8'h00, 8'h96, 1'b0, 1'b0};
        table_rows[6]  = '{2'd2, OP_READ,  7'h33, 8'h00, 8'h0F, 1'b0, 1'b0};
        table_rows[7]  = '{2'd3, OP_READ,  7'h44, 8'h00, 8'hE1, 1'b1, 1'b0};
        table_rows[8]  = '{2'd3, OP_READ,  7'h65, 8'h00, 8'h81, 1'b0, 1'b1};
        table_rows[9]  = '{2'd2, OP_READ,  7'h0C, 8'h00, 8'h7E, 1'b0, 1'b1};
        table_rows[10] = '{2'd1, OP_READ,  7'h47, 8'h00, 8'hD2, 1'b0, 1'b1};
        table_rows[11] = '{2'd0, OP_READ,  7'h39, 8'h00, 8'h24, 1'b1, 1'b1};
        table_rows[12] = '{2'd1, OP_WRITE, 7'h00, 8'hFF, 8'h00, 1'b1, 1'b0};
    endtask

    task automatic check_idle();
        check_val("scl_o", 32'(scl), 32'hF);
        check_val("sda_o", 32'(sda), 32'hF);
        check_val("sda_en_o", 32'(sda_en), 32'hF);
    endtask

    task automatic send_cmd(input row_t row);
        int t;
        @(posedge clk);
        cmd       <= '{chan: row.chan, data: row.wdata, op: row.op, addr: row.addr};
        cmd_valid <= 1'b1;
        t = 0;
        while (1) begin
            @(negedge clk);
            if (cmd_ready) break;
            t++;
            if (t > TIMEOUT) begin
                timeouts++;
                $display("Timeout: command for channel %0d was never accepted", row.chan);
                break;
            end
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_frames();
        int  t;
        bit  done;
        t = 0;
        while (1) begin
            @(negedge clk);
            done = 1'b1;
            for (int ch = 0; ch < 4; ch++) begin
                if (frame_cnt[ch] != exp_frames[ch]) done = 1'b0;
            end
            if (done) break;
            t++;
            if (t > TIMEOUT) begin
                timeouts++;
                $display("Timeout: bus frames did not finish");
                break;
            end
        end
    endtask

    task automatic wait_rsps(input int n);
        int t;
        t = 0;
        while (rsp_q.size() < n) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                timeouts++;
                $display("Timeout: expected responses did not arrive");
                break;
            end
        end
        repeat (10) @(negedge clk); // Catch duplicates.
    endtask

    task automatic finish_group(input bit hold);
        int       reads;
        bit       used [NUM_ROWS];
        bit       found;
        bit       in_grp [4];
        row_t     row;
        i2c_rsp_t held;
        reads = 0;
        foreach (used[i]) used[i] = 1'b0;
        foreach (in_grp[i]) in_grp[i] = 1'b0;
        foreach (grp[i]) begin
            if (table_rows[grp[i]].op == OP_READ) reads++;
            in_grp[table_rows[grp[i]].chan] = 1'b1;
        end
        wait_frames();
        if (hold) begin
            held = rsp;
            // Stalled word must stay valid and unchanged.
            for (int k = 0; k < 10; k++) begin
                @(negedge clk);
                check_val("rsp_valid_o", 32'(rsp_valid), 32'h1);
                check_val("rsp_o", 32'(rsp), 32'(held));
            end
            @(posedge clk);
            rsp_ready <= 1'b1;
        end
        wait_rsps(reads);
        foreach (grp[i]) begin
            row = table_rows[grp[i]];
            check_val("frame addr", 32'(frame_log[row.chan][6:0]), 32'(row.addr));
            check_val("frame op", 32'(frame_log[row.chan][7]), 32'(row.op));
            check_val("frame data", 32'(frame_log[row.chan][16:9]),
                      (row.op == OP_WRITE) ? 32'(row.wdata) : 32'(row.rdata));
        end
        foreach (rsp_q[r]) begin
            found = 1'b0;
            foreach (grp[i]) begin
                row = table_rows[grp[i]];
                if (!found && !used[i] && row.op == OP_READ && row.chan == rsp_q[r].chan) begin
                    used[i] = 1'b1;
                    found   = 1'b1;
                    check_val("rsp_o.addr", 32'(rsp_q[r].addr), 32'(row.addr));
                    check_val("rsp_o.data", 32'(rsp_q[r].data), 32'(row.rdata));
                end
            end
            check_true(found, "response for a channel with no open read");
        end
        check_val("response count", 32'(rsp_q.size()), 32'(reads));
        for (int ch = 0; ch < 4; ch++) begin
            if (in_grp[ch]) begin
                check_true(edge_cnt[ch] > edge_snap[ch], "named channel SCL never toggled");
            end else begin
                check_val($sformatf("scl_o[%0d] edges", ch), 32'(edge_cnt[ch]),
                          32'(edge_snap[ch]));
            end
        end
        check_idle();
        rsp_q.delete();
    endtask

    initial begin
        cmd        = '0;
        cmd_valid  = 1'b0;
        rsp_ready  = 1'b1;
        arstn      = 1'b0;
        value_errs = 0;
        other_errs = 0;
        timeouts   = 0;
        for (int ch = 0; ch < 4; ch++) begin
            rd_byte[ch]    = 8'h00;
            exp_frames[ch] = 0;
        end
        load_table();
        repeat (8) @(posedge clk);
        arstn <= 1'b1;
        @(negedge clk);
        check_idle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (grp.size() == 0) begin
                for (int ch = 0; ch < 4; ch++) edge_snap[ch] = edge_cnt[ch];
                if (table_rows[r].hold) begin
                    @(posedge clk);
                    rsp_ready <= 1'b0;
                end
            end
            grp.push_back(r);
            rd_byte[table_rows[r].chan] = table_rows[r].rdata;
            exp_frames[table_rows[r].chan]++;
            send_cmd(table_rows[r]);
            if (table_rows[r].last) begin
                finish_group(table_rows[r].hold);
                grp.delete();
            end
        end
        $display("Summary: %0d value errors, %0d other errors, %0d timeouts",
                 value_errs, other_errs, timeouts);
        if ((value_errs + other_errs + timeouts) == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/i2c_bridge_pkg.sv
logic/i2c_cmd_dispatch.sv
logic/i2c_bus_engine.sv
logic/i2c_rsp_collect.sv
logic/i2c_bridge_top.sv
bench/i2c_target_model.sv
bench/i2c_bridge_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module i2c_bridge_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vi2c_bridge_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
